//--- uart_regs_top.f
source/uart_pkg.sv
source/uart_fifo.sv
source/uart_baud_gen.sv
source/uart_wb_regs.sv
source/uart_transmitter.sv
source/uart_receiver.sv
source/uart_regs_top.sv
test/uart_regs_assertions.sv
test/uart_regs_tb.sv

//--- Bender.yml
package:
  name: uart_regs

sources:
  - files:
      - source/uart_pkg.sv
      - source/uart_fifo.sv
      - source/uart_baud_gen.sv
      - source/uart_wb_regs.sv
      - source/uart_transmitter.sv
      - source/uart_receiver.sv
      - source/uart_regs_top.sv
  - target: test
    files:
      - test/uart_regs_assertions.sv
      - test/uart_regs_tb.sv

//--- test/uart_regs_tb.sv
/*
 * Testbench for the UART register block.
 * Drives the Wishbone port, loops back or forges serial frames
 * and compares received entries with a reference model.
 */
`timescale 1ns/100ps
`default_nettype none

module uart_regs_tb;

	logic                        clk;
	logic                        wb_rst_i;
	logic                        wb_cyc_i;
	logic                        wb_stb_i;
	logic                        wb_we_i;
	logic [uart_pkg::ADDR_W-1:0] wb_adr_i;
	logic [7:0]                  wb_dat_i;
	logic [7:0]                  wb_dat_o;
	logic                        wb_ack_o;
	logic                        stx_o;
	logic                        srx_i;
	logic                        loop_en;    // stx_o wired back to srx_i
	logic                        forge_line; // line from the frame model
	integer                      seed;
	int                          div;        // current divisor
	int                          errors;
	int                          checks;
	int                          err_mark;   // counts at start of test
	int                          chk_mark;

	assign srx_i = loop_en ? stx_o : forge_line;

	uart_regs_top dut0 (
		.clk(clk), .wb_rst_i(wb_rst_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i), .wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o),
		.wb_ack_o(wb_ack_o), .stx_o(stx_o), .srx_i(srx_i)
	);

	bind uart_regs_top uart_regs_assertions asrt0 (
		.clk(clk), .wb_rst_i(wb_rst_i), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
		.wb_we_i(wb_we_i), .wb_ack_o(wb_ack_o), .stx_o(stx_o)
	);

	always #5 clk = ~clk; // 10 ns period

	task automatic bus_cycle(input logic we, input logic [uart_pkg::ADDR_W-1:0] adr,
		input logic [7:0] wdat, output logic [7:0] rdat);
		int n;
		@(posedge clk);
		#1;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = we;
		wb_adr_i = adr;
		wb_dat_i = wdat;
		n = 0;
		do
		begin
			@(posedge clk);
			#1;
			n++;
		end
		while (!wb_ack_o && n < 8);
		if (!wb_ack_o)
		begin
			$display("bus error: no ack for access to address %0d", adr);
			errors++;
		end
		rdat = wb_dat_o; // valid while ack high
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
	endtask

	task automatic wb_write(input logic [uart_pkg::ADDR_W-1:0] adr, input logic [7:0] dat);
		logic [7:0] unused;
		bus_cycle(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic [uart_pkg::ADDR_W-1:0] adr, output logic [7:0] dat);
		bus_cycle(1'b0, adr, 8'h00, dat);
	endtask

	// parity bit over the used data bits
	function automatic logic parity_of(input logic [7:0] b, input uart_pkg::frame_cfg_t cfg);
		logic p;
		p = 1'b0;
		for (int i = 0; i < 5 + cfg.word_len; i++)
			p ^= b[i];
		if (cfg.stick_par)
			return !cfg.even_par; // stick 1 or stick 0
		return cfg.even_par ? p : !p;
	endfunction

	// reference model of one receive entry
	function automatic uart_pkg::rx_entry_t expect_entry(input logic [7:0] b,
		input uart_pkg::frame_cfg_t cfg, input logic perr, input logic ferr);
		uart_pkg::rx_entry_t e;
		e.data = b & (8'hff >> (3 - cfg.word_len)); // unused bits read 0
		e.parity_err = perr & cfg.par_en;
		e.framing_err = ferr;
		return e;
	endfunction

	function automatic logic [7:0] lcr_of(input uart_pkg::frame_cfg_t cfg);
		return {2'b00, cfg.stick_par, cfg.even_par, cfg.par_en, 1'b0, cfg.word_len};
	endfunction

	task automatic drive_bit(input logic v);
		forge_line = v;
		repeat (uart_pkg::OVERSAMPLE * div) @(posedge clk);
		#1;
	endtask

	// forged frame, optional bad parity or low stop, then one idle bit
	task automatic send_frame(input logic [7:0] b, input uart_pkg::frame_cfg_t cfg,
		input logic bad_par, input logic bad_stop);
		@(posedge clk);
		#1;
		drive_bit(1'b0);
		for (int i = 0; i < 5 + cfg.word_len; i++)
			drive_bit(b[i]); // lsb first
		if (cfg.par_en)
			drive_bit(parity_of(b, cfg) ^ bad_par);
		drive_bit(!bad_stop);
		drive_bit(1'b1);
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		checks++;
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s got %02h expected %02h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_entry(input uart_pkg::rx_entry_t got, input uart_pkg::rx_entry_t exp,
		input string what);
		checks++;
		if (got !== exp)
		begin
			$display("FAILED at %0t: %s got %02h/%0b/%0b expected %02h/%0b/%0b", $time, what,
				got.data, got.parity_err, got.framing_err,
				exp.data, exp.parity_err, exp.framing_err);
			errors++;
		end
	endtask

	// lsr first, the rbr read pops the head
	task automatic read_entry(output uart_pkg::rx_entry_t e);
		logic [7:0] lsr;
		logic [7:0] rbr;
		wb_read(uart_pkg::REG_LSR, lsr);
		wb_read(uart_pkg::REG_DATA, rbr);
		e.data = rbr;
		e.parity_err = lsr[2];
		e.framing_err = lsr[3];
	endtask

	task automatic wait_lsr(input int bitn, input string what);
		logic [7:0] lsr;
		int n;
		lsr = '0;
		n = 0;
		while (!lsr[bitn] && n < 12 * uart_pkg::OVERSAMPLE * div)
		begin
			wb_read(uart_pkg::REG_LSR, lsr);
			n++;
		end
		if (!lsr[bitn])
		begin
			$display("%s never came up in LSR", what);
			errors++;
		end
	endtask

	task automatic loop_byte(input logic [7:0] b, input uart_pkg::frame_cfg_t cfg);
		uart_pkg::rx_entry_t got;
		wb_write(uart_pkg::REG_DATA, b);
		wait_lsr(0, "data ready");
		read_entry(got);
		check_entry(got, expect_entry(b, cfg, 1'b0, 1'b0), "loopback entry");
	endtask

	task automatic report_test(input string name);
		$display("test %s: %0d checks, %0d errors", name, checks - chk_mark, errors - err_mark);
		chk_mark = checks;
		err_mark = errors;
	endtask

	initial
	begin
		uart_pkg::frame_cfg_t cfg;
		uart_pkg::rx_entry_t  got;
		logic [7:0]           rd;
		logic [7:0]           b;
		logic [7:0]           sent [$];
		clk = 1'b0;
		wb_rst_i = 1'b1;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		loop_en = 1'b0;
		forge_line = 1'b1; // idle high
		seed = 86091;
		div = 0;
		errors = 0;
		checks = 0;
		err_mark = 0;
		chk_mark = 0;
		repeat (5) @(posedge clk);
		#1;
		wb_rst_i = 1'b0;

		wb_read(uart_pkg::REG_LCR, rd);
		check_byte(rd, 8'h03, "LCR after reset");
		wb_read(uart_pkg::REG_LSR, rd);
		check_byte(rd, 8'h60, "LSR after reset");
		check_byte({7'd0, stx_o}, 8'h01, "stx_o after reset");
		report_test("reset values");

		wb_write(uart_pkg::REG_LCR, 8'h83); // dlab set
		wb_write(uart_pkg::REG_DATA, 8'h5a);
		wb_write(uart_pkg::REG_DLM, 8'ha5);
		wb_read(uart_pkg::REG_DATA, rd);
		check_byte(rd, 8'h5a, "divisor low byte");
		wb_read(uart_pkg::REG_DLM, rd);
		check_byte(rd, 8'ha5, "divisor high byte");
		wb_write(uart_pkg::REG_DATA, 8'h02);
		wb_write(uart_pkg::REG_DLM, 8'h00);
		div = 2;
		wb_write(uart_pkg::REG_LCR, 8'h03);
		wb_read(uart_pkg::REG_DLM, rd);
		check_byte(rd, 8'h00, "DLM with DLAB clear");
		report_test("divisor latch");

		loop_en = 1'b1;
		cfg = '{word_len: 2'd3, par_en: 1'b0, even_par: 1'b0, stick_par: 1'b0}; // 8n1
		for (int i = 0; i < 20; i++)
		begin
			b = 8'($random(seed));
			loop_byte(b, cfg);
		end
		wait_lsr(6, "TEMT");
		wb_read(uart_pkg::REG_LSR, rd);
		check_byte(rd, 8'h60, "LSR after last byte");
		report_test("loopback 8N1");

		for (int wl = 0; wl < 3; wl++)
			for (int pm = 0; pm < 4; pm++)
			begin
				cfg.word_len = 2'(wl);
				cfg.par_en = 1'b1;
				cfg.even_par = pm[0];  // odd, even, stick 1, stick 0
				cfg.stick_par = pm[1];
				wb_write(uart_pkg::REG_LCR, lcr_of(cfg));
				for (int k = 0; k < 2; k++)
				begin
					b = 8'($random(seed));
					loop_byte(b, cfg);
				end
				loop_en = 1'b0; // tx sits in its stop bit, line stays high
				send_frame(b, cfg, 1'b1, 1'b0);
				read_entry(got);
				check_entry(got, expect_entry(b, cfg, 1'b1, 1'b0), "forged parity entry");
				loop_en = 1'b1;
			end
		report_test("word lengths and parity");

		wait_lsr(6, "TEMT");
		loop_en = 1'b0;
		cfg = '{word_len: 2'd3, par_en: 1'b1, even_par: 1'b1, stick_par: 1'b0}; // 8e1
		wb_write(uart_pkg::REG_LCR, lcr_of(cfg));
		for (int i = 0; i < 4; i++)
		begin
			b = 8'($random(seed));
			sent.push_back(b);
			send_frame(b, cfg, i[0], i[1]); // none, parity, stop, both
		end
		for (int i = 0; i < 4; i++)
		begin
			read_entry(got);
			check_entry(got, expect_entry(sent[i], cfg, i[0], i[1]), "forged entry");
		end
		report_test("parity and framing errors");

		sent.delete();
		cfg = '{word_len: 2'd3, par_en: 1'b0, even_par: 1'b0, stick_par: 1'b0};
		wb_write(uart_pkg::REG_LCR, lcr_of(cfg));
		for (int i = 0; i < 17; i++)
		begin
			b = 8'($random(seed));
			sent.push_back(b);
			send_frame(b, cfg, 1'b0, 1'b0);
		end
		wb_read(uart_pkg::REG_LSR, rd);
		check_byte(rd & 8'h03, 8'h03, "data ready and overrun");
		wb_read(uart_pkg::REG_LSR, rd);
		check_byte(rd & 8'h02, 8'h00, "overrun after LSR read");
		for (int i = 0; i < 16; i++)
		begin
			wb_read(uart_pkg::REG_DATA, rd);
			check_byte(rd, sent[i], "RBR in order");
		end
		wb_read(uart_pkg::REG_LSR, rd);
		check_byte(rd & 8'h01, 8'h00, "data ready after drain");
		report_test("overrun");

		errors += dut0.asrt0.fails; // bound assertion failures
		$display("all tests: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

	initial
	begin
		longint limit_ns;
		// 77 frames of at most 12 bits at divisor 2, doubled, plus margin
		limit_ns = 77 * 12 * uart_pkg::OVERSAMPLE * 2 * 10 * 2 + 50000;
		#(limit_ns);
		$display("timeout: the tests did not finish within %0d ns", limit_ns);
		$display("Finished with errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/uart_regs_assertions.sv
/*
 * Bus handshake and serial line checks, bound into the UART top level.
 */
`timescale 1ns/100ps
`default_nettype none

module uart_regs_assertions (
	input logic clk,
	input logic wb_rst_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic wb_we_i,
	input logic wb_ack_o,
	input logic stx_o
);

	logic wr_seen_q;  // a write request has been made
	int   fails = 0;  // failed assertion count

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
			wr_seen_q <= 1'b0;
		else if (wb_cyc_i && wb_stb_i && wb_we_i)
			wr_seen_q <= 1'b1;
	end

	// ack answers a request seen on the previous edge
	ack_on_request: assert property (@(posedge clk) disable iff (wb_rst_i)
		wb_ack_o |-> $past(wb_cyc_i && wb_stb_i))
		else begin fails++; $error("ack without a bus request"); end

	ack_single: assert property (@(posedge clk) disable iff (wb_rst_i)
		wb_ack_o |=> !wb_ack_o)
		else begin fails++; $error("ack high two cycles in a row"); end

	line_idle: assert property (@(posedge clk) disable iff (wb_rst_i)
		!wr_seen_q |-> stx_o)  // nothing to send yet
		else begin fails++; $error("serial output low before any write"); end

endmodule

`default_nettype wire

//--- source/uart_regs_top.sv
/*
 * UART register block top level.
 * Wishbone register file, baud generator, tx/rx FIFOs and serializers.
 */
`timescale 1ns/100ps
`default_nettype none

module uart_regs_top (
	input  logic                       clk,
	input  logic                       wb_rst_i,
	input  logic                       wb_cyc_i,
	input  logic                       wb_stb_i,
	input  logic                       wb_we_i,
	input  logic [uart_pkg::ADDR_W-1:0] wb_adr_i,
	input  logic [7:0]                 wb_dat_i,
	output logic [7:0]                 wb_dat_o,
	output logic                       wb_ack_o,
	output logic                       stx_o,
	input  logic                       srx_i
);

	uart_pkg::frame_cfg_t          cfg;
	logic [uart_pkg::DIV_W-1:0]    divisor;
	logic                          tick;
	logic                          tx_push;      // register write into tx fifo
	logic [uart_pkg::DATA_W-1:0]   tx_dat;
	logic                          tx_pop;       // transmitter takes the head
	logic [uart_pkg::DATA_W-1:0]   tx_head;
	logic                          tx_empty;
	logic                          tx_idle;
	logic                          rx_push;
	uart_pkg::rx_entry_t           rx_entry;
	logic                          rx_pop;
	uart_pkg::rx_entry_t           rx_head;
	logic                          rx_empty;
	logic                          rx_overflow;  // entry lost, feeds lsr overrun

	uart_wb_regs regs0 (
		.clk(clk), .wb_rst_i(wb_rst_i),
		.wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .wb_we_i(wb_we_i),
		.wb_adr_i(wb_adr_i), .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack_o(wb_ack_o),
		.cfg_o(cfg), .divisor_o(divisor),
		.tx_push_o(tx_push), .tx_dat_o(tx_dat), .tx_empty_i(tx_empty), .tx_idle_i(tx_idle),
		.rx_pop_o(rx_pop), .rx_head_i(rx_head), .rx_empty_i(rx_empty),
		.rx_overflow_i(rx_overflow)
	);

	uart_baud_gen baud0 (.clk(clk), .wb_rst_i(wb_rst_i), .divisor_i(divisor), .tick_o(tick));

	// writes into a full tx fifo are simply dropped
	uart_fifo #(.WIDTH(uart_pkg::DATA_W)) tx_fifo0 (
		.clk(clk), .wb_rst_i(wb_rst_i), .push_i(tx_push), .data_i(tx_dat),
		.pop_i(tx_pop), .data_o(tx_head), .empty_o(tx_empty), .full_o(),
		.overflow_o()
	);

	uart_fifo #(.WIDTH($bits(uart_pkg::rx_entry_t))) rx_fifo0 (
		.clk(clk), .wb_rst_i(wb_rst_i), .push_i(rx_push), .data_i(rx_entry),
		.pop_i(rx_pop), .data_o(rx_head), .empty_o(rx_empty), .full_o(),
		.overflow_o(rx_overflow)
	);

	uart_transmitter tx0 (
		.clk(clk), .wb_rst_i(wb_rst_i), .tick_i(tick), .cfg_i(cfg),
		.fifo_empty_i(tx_empty), .fifo_dat_i(tx_head), .pop_o(tx_pop),
		.idle_o(tx_idle), .stx_o(stx_o)
	);

	uart_receiver rx0 (
		.clk(clk), .wb_rst_i(wb_rst_i), .tick_i(tick), .cfg_i(cfg),
		.srx_i(srx_i), .push_o(rx_push), .entry_o(rx_entry)
	);

endmodule

`default_nettype wire

//--- source/uart_receiver.sv
/*
 * UART receiver.
 * Synchronizes srx_i, detects the start edge, samples mid-bit,
 * checks parity and stop, and pushes one entry per frame.
 */
`timescale 1ns/100ps
`default_nettype none

module uart_receiver (
	input  logic                 clk,
	input  logic                 wb_rst_i,
	input  logic                 tick_i,
	input  uart_pkg::frame_cfg_t cfg_i,
	input  logic                 srx_i,
	output logic                 push_o,
	output uart_pkg::rx_entry_t  entry_o
);

	logic                         rx_s1_q;   // synchronizer stage 1
	logic                         rx_s2_q;   // synchronized line
	logic                         rx_prev_q; // for edge detect
	uart_pkg::rx_state_e          state_q;
	uart_pkg::frame_cfg_t         cfg_q;
	logic [7:0]                   shift_q;
	logic [2:0]                   bit_q;
	logic [uart_pkg::TICK_W-1:0]  tcnt_q;
	logic                         par_err_q;
	logic                         start_edge;
	logic                         sample;    // middle of a bit

	assign start_edge = rx_prev_q & ~rx_s2_q;
	assign sample = tick_i & (tcnt_q == uart_pkg::TICK_LAST);

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			rx_s1_q <= 1'b1;
			rx_s2_q <= 1'b1;
			rx_prev_q <= 1'b1;
			state_q <= uart_pkg::RX_IDLE;
			bit_q <= '0;
			tcnt_q <= '0;
			push_o <= 1'b0;
		end
		else
		begin
			rx_s1_q <= srx_i;
			rx_s2_q <= rx_s1_q;
			rx_prev_q <= rx_s2_q;
			push_o <= (state_q == uart_pkg::RX_STOP) & sample;
			if (tick_i)
				tcnt_q <= tcnt_q + 1'b1;
			case (state_q)
				uart_pkg::RX_IDLE:
					if (start_edge)
					begin
						state_q <= uart_pkg::RX_START;
						tcnt_q <= '0;
						bit_q <= '0;
					end
				uart_pkg::RX_START:
					if (tick_i && tcnt_q == uart_pkg::TICK_MID)
					begin
						tcnt_q <= '0; // realign on start bit middle
						state_q <= rx_s2_q ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA; // glitch
					end
				uart_pkg::RX_DATA:
					if (sample)
					begin
						if (bit_q == {1'b1, cfg_q.word_len})
							state_q <= cfg_q.par_en ? uart_pkg::RX_PARITY : uart_pkg::RX_STOP;
						else
							bit_q <= bit_q + 1'b1;
					end
				uart_pkg::RX_PARITY:
					if (sample)
						state_q <= uart_pkg::RX_STOP;
				uart_pkg::RX_STOP:
					if (sample)
						state_q <= uart_pkg::RX_IDLE; // ready for back-to-back start
				default: state_q <= uart_pkg::RX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		case (state_q)
			uart_pkg::RX_IDLE:
				if (start_edge)
				begin
					cfg_q <= cfg_i;
					shift_q <= '0;    // unused upper bits stay 0
					par_err_q <= 1'b0;
				end
			uart_pkg::RX_DATA:
				if (sample)
					shift_q[bit_q] <= rx_s2_q;
			uart_pkg::RX_PARITY:
				if (sample)
					par_err_q <= (rx_s2_q != uart_pkg::calc_parity(shift_q, cfg_q));
			uart_pkg::RX_STOP:
				if (sample)
					entry_o <= '{data: shift_q, parity_err: par_err_q, framing_err: ~rx_s2_q};
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- source/uart_transmitter.sv
/*
 * UART transmitter.
 * Pops the tx FIFO and sends start, 5..8 data bits LSB first,
 * optional parity and one stop bit, 16 ticks per bit.
 */
`timescale 1ns/100ps
`default_nettype none

module uart_transmitter (
	input  logic                 clk,
	input  logic                 wb_rst_i,
	input  logic                 tick_i,
	input  uart_pkg::frame_cfg_t cfg_i,
	input  logic                 fifo_empty_i,
	input  logic [7:0]           fifo_dat_i,
	output logic                 pop_o,
	output logic                 idle_o,
	output logic                 stx_o
);

	uart_pkg::tx_state_e          state_q;
	uart_pkg::frame_cfg_t         cfg_q;    // format frozen for the frame
	logic [7:0]                   shift_q;
	logic                         par_q;
	logic [2:0]                   bit_q;    // data bit index
	logic [uart_pkg::TICK_W-1:0]  tcnt_q;
	logic                         bit_end;  // last tick of current bit
	logic                         line;

	assign idle_o = (state_q == uart_pkg::TX_IDLE);
	assign pop_o = idle_o & ~fifo_empty_i;
	assign bit_end = tick_i & (tcnt_q == uart_pkg::TICK_LAST);

	always_comb
	begin
		case (state_q)
			uart_pkg::TX_START:  line = 1'b0;
			uart_pkg::TX_DATA:   line = shift_q[0];
			uart_pkg::TX_PARITY: line = par_q;
			default:             line = 1'b1; // idle and stop
		endcase
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			state_q <= uart_pkg::TX_IDLE;
			bit_q <= '0;
			tcnt_q <= '0;
			stx_o <= 1'b1; // line idles high
		end
		else
		begin
			stx_o <= line;
			if (tick_i && !idle_o)
				tcnt_q <= tcnt_q + 1'b1; // wraps every bit
			case (state_q)
				uart_pkg::TX_IDLE:
					if (!fifo_empty_i)
					begin
						state_q <= uart_pkg::TX_START;
						tcnt_q <= '0;
						bit_q <= '0;
					end
				uart_pkg::TX_START:
					if (bit_end)
						state_q <= uart_pkg::TX_DATA;
				uart_pkg::TX_DATA:
					if (bit_end)
					begin
						if (bit_q == {1'b1, cfg_q.word_len}) // 4 + word_len
							state_q <= cfg_q.par_en ? uart_pkg::TX_PARITY : uart_pkg::TX_STOP;
						else
							bit_q <= bit_q + 1'b1;
					end
				uart_pkg::TX_PARITY:
					if (bit_end)
						state_q <= uart_pkg::TX_STOP;
				uart_pkg::TX_STOP:
					if (bit_end)
						state_q <= uart_pkg::TX_IDLE;
				default: state_q <= uart_pkg::TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (pop_o)
		begin
			shift_q <= fifo_dat_i;
			cfg_q <= cfg_i;
			par_q <= uart_pkg::calc_parity(fifo_dat_i, cfg_i);
		end
		else if (state_q == uart_pkg::TX_DATA && bit_end)
			shift_q <= shift_q >> 1; // next bit to lsb
	end

endmodule

`default_nettype wire

//--- source/uart_wb_regs.sv
/*
 * Wishbone classic slave for the UART registers.
 * Holds LCR and the divisor latch, assembles LSR and
 * strobes the tx/rx FIFOs on data register accesses.
 */
`timescale 1ns/100ps
`default_nettype none

module uart_wb_regs (
	input  logic                        clk,
	input  logic                        wb_rst_i,
	input  logic                        wb_cyc_i,
	input  logic                        wb_stb_i,
	input  logic                        wb_we_i,
	input  logic [uart_pkg::ADDR_W-1:0] wb_adr_i,
	input  logic [7:0]                  wb_dat_i,
	output logic [7:0]                  wb_dat_o,
	output logic                        wb_ack_o,
	output uart_pkg::frame_cfg_t        cfg_o,
	output logic [uart_pkg::DIV_W-1:0]  divisor_o,
	output logic                        tx_push_o,
	output logic [7:0]                  tx_dat_o,
	input  logic                        tx_empty_i,
	input  logic                        tx_idle_i,
	output logic                        rx_pop_o,
	input  uart_pkg::rx_entry_t         rx_head_i,
	input  logic                        rx_empty_i,
	input  logic                        rx_overflow_i
);

	uart_pkg::lcr_t             lcr_q;
	logic [uart_pkg::DIV_W-1:0] dl_q;      // divisor latch
	logic                       ack_q;
	logic                       overrun_q; // sticky until lsr read
	logic                       acc;       // request not yet acknowledged
	logic                       wr;
	logic                       rd;
	logic [7:0]                 lsr;
	logic [7:0]                 rd_data;

	assign acc = wb_cyc_i & wb_stb_i & ~ack_q; // no back-to-back ack
	assign wr = acc & wb_we_i;
	assign rd = acc & ~wb_we_i;
	assign wb_ack_o = ack_q;
	assign divisor_o = dl_q;
	assign cfg_o = '{word_len: lcr_q.word_len, par_en: lcr_q.par_en,
		even_par: lcr_q.even_par, stick_par: lcr_q.stick_par};

	// thr write and rbr read only with dlab clear
	assign tx_push_o = wr & ~lcr_q.dlab & (wb_adr_i == uart_pkg::REG_DATA);
	assign tx_dat_o = wb_dat_i;
	assign rx_pop_o = rd & ~lcr_q.dlab & (wb_adr_i == uart_pkg::REG_DATA) & ~rx_empty_i;

	always_comb
	begin
		lsr = '0;
		lsr[0] = ~rx_empty_i;                         // data ready
		lsr[1] = overrun_q;
		lsr[2] = ~rx_empty_i & rx_head_i.parity_err;  // flags of the head entry
		lsr[3] = ~rx_empty_i & rx_head_i.framing_err;
		lsr[5] = tx_empty_i;                          // thre
		lsr[6] = tx_empty_i & tx_idle_i;              // temt
	end

	always_comb
	begin
		rd_data = '0; // unmapped addresses read 0
		case (wb_adr_i)
			uart_pkg::REG_DATA:
				if (lcr_q.dlab)
					rd_data = dl_q[7:0];
				else if (!rx_empty_i)
					rd_data = rx_head_i.data;
			uart_pkg::REG_DLM:
				if (lcr_q.dlab)
					rd_data = dl_q[15:8];
			uart_pkg::REG_LCR: rd_data = lcr_q;
			uart_pkg::REG_LSR: rd_data = lsr;
			default: rd_data = '0;
		endcase
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			ack_q <= 1'b0;
			lcr_q <= uart_pkg::LCR_RESET;
			dl_q <= '0;      // no ticks until programmed
			overrun_q <= 1'b0;
		end
		else
		begin
			ack_q <= acc;
			if (wr && wb_adr_i == uart_pkg::REG_LCR)
				lcr_q <= wb_dat_i;
			if (wr && lcr_q.dlab && wb_adr_i == uart_pkg::REG_DATA)
				dl_q[7:0] <= wb_dat_i;
			if (wr && lcr_q.dlab && wb_adr_i == uart_pkg::REG_DLM)
				dl_q[15:8] <= wb_dat_i;
			if (rx_overflow_i)
				overrun_q <= 1'b1;   // new loss wins over a clearing read
			else if (rd && wb_adr_i == uart_pkg::REG_LSR)
				overrun_q <= 1'b0;
		end
	end

	// read data captured with ack, holds until next read
	always_ff @(posedge clk)
	begin
		if (rd)
			wb_dat_o <= rd_data;
	end

endmodule

`default_nettype wire

//--- source/uart_baud_gen.sv
/*
 * Baud rate generator.
 * One-cycle enable tick every divisor clocks, 16 ticks per bit.
 */
`timescale 1ns/100ps
`default_nettype none

module uart_baud_gen (
	input  logic                       clk,
	input  logic                       wb_rst_i,
	input  logic [uart_pkg::DIV_W-1:0] divisor_i,
	output logic                       tick_o
);

	logic [uart_pkg::DIV_W-1:0] cnt_q; // down counter
	logic [uart_pkg::DIV_W-1:0] div_q; // last divisor, detects changes

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			cnt_q <= '0;
			div_q <= '0;
			tick_o <= 1'b0;
		end
		else
		begin
			div_q <= divisor_i;
			tick_o <= 1'b0;
			if (divisor_i == '0)
				cnt_q <= '0;                  // silent
			else if (divisor_i != div_q)
				cnt_q <= divisor_i - 1'b1;    // restart on new divisor
			else if (cnt_q == '0)
			begin
				tick_o <= 1'b1;
				cnt_q <= divisor_i - 1'b1;    // reload
			end
			else
				cnt_q <= cnt_q - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- source/uart_fifo.sv
/*
 * Synchronous FIFO, FIFO_DEPTH entries of WIDTH bits.
 * Head visible on data_o, a push while full is dropped and flagged.
 */
`timescale 1ns/100ps
`default_nettype none

module uart_fifo #(
	parameter int WIDTH = 8
) (
	input  logic             clk,
	input  logic             wb_rst_i,
	input  logic             push_i,
	input  logic [WIDTH-1:0] data_i,
	input  logic             pop_i,
	output logic [WIDTH-1:0] data_o,
	output logic             empty_o,
	output logic             full_o,
	output logic             overflow_o
);

	logic [WIDTH-1:0]                mem [uart_pkg::FIFO_DEPTH];
	logic [uart_pkg::FIFO_PTR_W-1:0] wptr_q;
	logic [uart_pkg::FIFO_PTR_W-1:0] rptr_q;
	logic [uart_pkg::FIFO_CNT_W-1:0] count_q;
	logic                            do_push;
	logic                            do_pop;

	assign empty_o = (count_q == '0);
	assign full_o = (count_q == uart_pkg::FIFO_DEPTH);
	assign do_pop = pop_i & ~empty_o;
	assign do_push = push_i & (~full_o | do_pop); // room freed by same-cycle pop
	assign data_o = mem[rptr_q];

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wptr_q] <= data_i;
	end

	always_ff @(posedge clk or posedge wb_rst_i)
	begin
		if (wb_rst_i)
		begin
			wptr_q <= '0;
			rptr_q <= '0;
			count_q <= '0;
			overflow_o <= 1'b0;
		end
		else
		begin
			overflow_o <= push_i & ~do_push; // one pulse per lost word
			if (do_push)
				wptr_q <= wptr_q + 1'b1;      // wraps at depth
			if (do_pop)
				rptr_q <= rptr_q + 1'b1;
			if (do_push && !do_pop)
				count_q <= count_q + 1'b1;
			else if (do_pop && !do_push)
				count_q <= count_q - 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- source/uart_pkg.sv
/*
 * UART register block shared definitions.
 * Register map, sizes, frame format structs, FSM state types
 * and the parity rule used by both the transmitter and the receiver.
 */
`default_nettype none

package uart_pkg;

	localparam int ADDR_W     = 3;  // wishbone address bits
	localparam int DATA_W     = 8;  // byte width
	localparam int FIFO_DEPTH = 16; // entries per fifo
	localparam int FIFO_CNT_W = 5;  // holds 0..FIFO_DEPTH
	localparam int FIFO_PTR_W = 4;  // fifo index width
	localparam int DIV_W      = 16; // divisor latch width
	localparam int OVERSAMPLE = 16; // ticks per bit
	localparam int TICK_W     = 4;  // tick counter width

	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(OVERSAMPLE - 1);   // last tick of a bit
	localparam logic [TICK_W-1:0] TICK_MID  = TICK_W'(OVERSAMPLE/2 - 1); // middle of start bit

	// register map
	localparam logic [ADDR_W-1:0] REG_DATA = 3'd0; // thr / rbr, dll under dlab
	localparam logic [ADDR_W-1:0] REG_DLM  = 3'd1; // dlm under dlab
	localparam logic [ADDR_W-1:0] REG_LCR  = 3'd3;
	localparam logic [ADDR_W-1:0] REG_LSR  = 3'd5;

	localparam logic [DATA_W-1:0] LCR_RESET = 8'h03; // 8n1

	typedef struct packed {
		logic       dlab;      // divisor latch access
		logic       brk;       // stored only
		logic       stick_par;
		logic       even_par;
		logic       par_en;
		logic       stop2;     // stored only
		logic [1:0] word_len;  // data bits minus 5
	} lcr_t;

	// frame format seen by tx and rx
	typedef struct packed {
		logic [1:0] word_len;
		logic       par_en;
		logic       even_par;
		logic       stick_par;
	} frame_cfg_t;

	// rx fifo word
	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic              parity_err;
		logic              framing_err;
	} rx_entry_t;

	typedef enum logic [2:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_PARITY,
		TX_STOP
	} tx_state_e;

	typedef enum logic [2:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_PARITY,
		RX_STOP
	} rx_state_e;

	// expected parity bit for a character under the given format
	function automatic logic calc_parity(input logic [DATA_W-1:0] data, input frame_cfg_t cfg);
		logic [DATA_W-1:0] mask;
		logic              x;
		mask = {DATA_W{1'b1}} >> (2'd3 - cfg.word_len); // keep only used bits
		x = ^(data & mask);
		if (cfg.stick_par)
			return ~cfg.even_par; // stick 1 when eps clear, stick 0 when set
		return cfg.even_par ? x : ~x;
	endfunction

endpackage

`default_nettype wire
